//--- wdt_pkg.sv
package wdt_pkg;

	// Bus widths
	localparam int ADDR_W = 2;
	localparam int DATA_W = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [7:0]        byte_t;

	// Register offsets
	localparam addr_t ADDR_TCSR_TCNT_W = 2'd0;
	localparam addr_t ADDR_TCNT_R      = 2'd1;
	localparam addr_t ADDR_RSTCSR      = 2'd2;

	// Upper byte write keys
	localparam byte_t KEY_TCSR = 8'hA5;
	localparam byte_t KEY_TCNT = 8'h5A;

	// TCSR layout
	localparam int TCSR_OVF_BIT = 7;
	localparam int TCSR_WT_BIT  = 6;
	localparam int TCSR_TME_BIT = 5;
	localparam int CKS_W        = 3;

	// RSTCSR layout
	localparam int RSTCSR_WOVF_BIT = 7;

	// Prescaler
	localparam int PRESC_W  = 13;
	localparam int NUM_TAPS = 8;

	// Low count bits that must be all ones, per CKS value
	localparam int PRESC_TAPS [NUM_TAPS] = '{1, 6, 7, 8, 9, 10, 12, 13};

	typedef logic [NUM_TAPS-1:0] tap_vec_t;

	// WDTOVF_N low time in clocks
	localparam int WDTOVF_CYCLES = 32;
	localparam int WDTOVF_CNT_W  = $clog2(WDTOVF_CYCLES);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_DONE
	} bus_state_e;

	typedef enum logic [1:0] {
		SEL_TCSR_TCNT,
		SEL_TCNT,
		SEL_RSTCSR,
		SEL_NONE
	} reg_sel_e;

endpackage

//--- clk_prescaler.sv
`timescale 1ns/1ps

module clk_prescaler
	import wdt_pkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	output tap_vec_t taps
);

	logic [PRESC_W-1:0] div_cnt;
	tap_vec_t           tap_hit;

	// Free running divider
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
		end
		else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Tap k fires when its low count bits are all ones
	for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
		assign tap_hit[k] = &div_cnt[PRESC_TAPS[k]-1:0];
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			taps <= '0;
		end
		else begin
			taps <= tap_hit;
		end
	end

endmodule

//--- wdt_bus_fsm.sv
`timescale 1ns/1ps

module wdt_bus_fsm
	import wdt_pkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,

	input  logic     req,
	input  logic     we,
	input  addr_t    addr,
	input  word_t    wdata,
	output logic     busy,
	output logic     ack,
	output word_t    rdata,

	output logic     acc,
	output logic     acc_we,
	output reg_sel_e acc_sel,
	output word_t    acc_wdata,
	input  word_t    reg_rdata
);

	bus_state_e state;
	reg_sel_e   sel_dec;
	logic       take;

	assign take = req && !busy;

	always_comb begin
		case (addr)
			ADDR_TCSR_TCNT_W: sel_dec = SEL_TCSR_TCNT;
			ADDR_TCNT_R:      sel_dec = SEL_TCNT;
			ADDR_RSTCSR:      sel_dec = SEL_RSTCSR;
			default:          sel_dec = SEL_NONE;
		endcase
	end

	// Request fields, held until the access is done
	always_ff @(posedge CLK) begin
		if (take) begin
			acc_we    <= we;
			acc_sel   <= sel_dec;
			acc_wdata <= wdata;
		end
	end

	// A pending request shows as busy while still in ST_IDLE
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			busy  <= 1'b0;
			rdata <= '0;
		end
		else begin
			if (take) begin
				busy <= 1'b1;
			end
			else if (state == ST_ACCESS) begin
				busy <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (busy) begin
						state <= ST_ACCESS;
					end
				end
				ST_ACCESS: begin
					state <= ST_DONE;
					rdata <= reg_rdata;
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign acc = (state == ST_ACCESS);
	assign ack = (state == ST_DONE);

endmodule

//--- wdt_regs.sv
`timescale 1ns/1ps

module wdt_regs
	import wdt_pkg::*;
(
	input  logic             CLK,
	input  logic             RST_N,

	input  logic             acc,
	input  logic             acc_we,
	input  reg_sel_e         acc_sel,
	input  word_t            acc_wdata,
	output word_t            reg_rdata,

	input  byte_t            tcnt,
	input  logic             it_ovf,
	input  logic             wt_ovf,
	output logic             tme,
	output logic             wt_mode,
	output logic [CKS_W-1:0] cks,
	output logic             tcnt_load,
	output byte_t            tcnt_wdata,
	output logic             iti_irq
);

	byte_t key;
	byte_t low;
	logic  wr;
	logic  tcsr_wr;
	logic  rstcsr_clr;
	logic  ovf;
	logic  wovf;
	byte_t tcsr_val;
	byte_t rstcsr_val;

	assign key = acc_wdata[DATA_W-1:8];
	assign low = acc_wdata[7:0];
	assign wr  = acc && acc_we;

	// Key decode
	assign tcsr_wr    = wr && acc_sel == SEL_TCSR_TCNT && key == KEY_TCSR;
	assign tcnt_load  = wr && acc_sel == SEL_TCSR_TCNT && key == KEY_TCNT;
	assign rstcsr_clr = wr && acc_sel == SEL_RSTCSR && key == KEY_TCSR && low == 8'h00;

	assign tcnt_wdata = low;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wt_mode <= 1'b0;
			tme     <= 1'b0;
			cks     <= '0;
			ovf     <= 1'b0;
			wovf    <= 1'b0;
		end
		else begin
			if (tcsr_wr) begin
				wt_mode <= low[TCSR_WT_BIT];
				tme     <= low[TCSR_TME_BIT];
				cks     <= low[CKS_W-1:0];
			end

			// OVF is write-0-to-clear, set wins
			if (it_ovf) begin
				ovf <= 1'b1;
			end
			else if (tcsr_wr && !low[TCSR_OVF_BIT]) begin
				ovf <= 1'b0;
			end

			if (wt_ovf) begin
				wovf <= 1'b1;
			end
			else if (rstcsr_clr) begin
				wovf <= 1'b0;
			end
		end
	end

	assign iti_irq = ovf && !wt_mode;

	always_comb begin
		tcsr_val = '0;
		tcsr_val[TCSR_OVF_BIT] = ovf;
		tcsr_val[TCSR_WT_BIT]  = wt_mode;
		tcsr_val[TCSR_TME_BIT] = tme;
		tcsr_val[CKS_W-1:0]    = cks;

		rstcsr_val = '0;
		rstcsr_val[RSTCSR_WOVF_BIT] = wovf;
	end

	always_comb begin
		case (acc_sel)
			SEL_TCSR_TCNT: reg_rdata = {8'h00, tcsr_val};
			SEL_TCNT:      reg_rdata = {8'h00, tcnt};
			SEL_RSTCSR:    reg_rdata = {8'h00, rstcsr_val};
			default:       reg_rdata = '0;
		endcase
	end

endmodule

//--- wdt_counter.sv
`timescale 1ns/1ps

module wdt_counter
	import wdt_pkg::*;
(
	input  logic             CLK,
	input  logic             RST_N,

	input  tap_vec_t         taps,
	input  logic             tme,
	input  logic             wt_mode,
	input  logic [CKS_W-1:0] cks,
	input  logic             tcnt_load,
	input  byte_t            tcnt_wdata,

	output byte_t            tcnt,
	output logic             it_ovf,
	output logic             wt_ovf,
	output logic             wdtovf_n
);

	logic                    tick;
	logic                    tme_q;
	logic [WDTOVF_CNT_W-1:0] pulse_cnt;

	assign tick = tme && taps[cks];

	// Stopping the timer clears TCNT, a load while stopped is kept
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tcnt   <= '0;
			tme_q  <= 1'b0;
			it_ovf <= 1'b0;
			wt_ovf <= 1'b0;
		end
		else begin
			tme_q  <= tme;
			it_ovf <= 1'b0;
			wt_ovf <= 1'b0;

			if (tcnt_load) begin
				tcnt <= tcnt_wdata;
			end
			else if (tme_q && !tme) begin
				tcnt <= '0;
			end
			else if (tick) begin
				tcnt <= tcnt + 8'd1;
				if (tcnt == 8'hFF) begin
					it_ovf <= !wt_mode;
					wt_ovf <= wt_mode;
				end
			end
		end
	end

	// WDTOVF_N low pulse
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wdtovf_n  <= 1'b1;
			pulse_cnt <= '0;
		end
		else begin
			if (wt_ovf) begin
				wdtovf_n  <= 1'b0;
				pulse_cnt <= WDTOVF_CNT_W'(WDTOVF_CYCLES - 1);
			end
			else if (!wdtovf_n) begin
				if (pulse_cnt == '0) begin
					wdtovf_n <= 1'b1;
				end
				else begin
					pulse_cnt <= pulse_cnt - 1'b1;
				end
			end
		end
	end

endmodule

//--- wdt_top.sv
`timescale 1ns/1ps

module wdt_top
	import wdt_pkg::*;
(
	input  logic  CLK,
	input  logic  RST_N,

	input  logic  req,
	input  logic  we,
	input  addr_t addr,
	input  word_t wdata,
	output logic  busy,
	output logic  ack,
	output word_t rdata,

	output logic  iti_irq,
	output logic  wdtovf_n
);

	tap_vec_t         taps;

	logic             acc;
	logic             acc_we;
	reg_sel_e         acc_sel;
	word_t            acc_wdata;
	word_t            reg_rdata;

	byte_t            tcnt;
	byte_t            tcnt_wdata;
	logic             tcnt_load;
	logic             tme;
	logic             wt_mode;
	logic [CKS_W-1:0] cks;
	logic             it_ovf;
	logic             wt_ovf;

	clk_prescaler u_presc (
		.CLK   (CLK),
		.RST_N (RST_N),
		.taps  (taps)
	);

	wdt_bus_fsm u_bus (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.req       (req),
		.we        (we),
		.addr      (addr),
		.wdata     (wdata),
		.busy      (busy),
		.ack       (ack),
		.rdata     (rdata),
		.acc       (acc),
		.acc_we    (acc_we),
		.acc_sel   (acc_sel),
		.acc_wdata (acc_wdata),
		.reg_rdata (reg_rdata)
	);

	wdt_regs u_regs (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.acc        (acc),
		.acc_we     (acc_we),
		.acc_sel    (acc_sel),
		.acc_wdata  (acc_wdata),
		.reg_rdata  (reg_rdata),
		.tcnt       (tcnt),
		.it_ovf     (it_ovf),
		.wt_ovf     (wt_ovf),
		.tme        (tme),
		.wt_mode    (wt_mode),
		.cks        (cks),
		.tcnt_load  (tcnt_load),
		.tcnt_wdata (tcnt_wdata),
		.iti_irq    (iti_irq)
	);

	wdt_counter u_cnt (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.taps       (taps),
		.tme        (tme),
		.wt_mode    (wt_mode),
		.cks        (cks),
		.tcnt_load  (tcnt_load),
		.tcnt_wdata (tcnt_wdata),
		.tcnt       (tcnt),
		.it_ovf     (it_ovf),
		.wt_ovf     (wt_ovf),
		.wdtovf_n   (wdtovf_n)
	);

endmodule

//--- wdt_properties.sv
`timescale 1ns/1ps

module wdt_properties
	import wdt_pkg::*;
(
	input logic CLK,
	input logic RST_N,
	input logic busy,
	input logic ack,
	input logic iti_irq,
	input logic wdtovf_n
);

	int low_len;

	// Low samples of WDTOVF_N so far
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			low_len <= 0;
		end
		else if (!wdtovf_n) begin
			low_len <= low_len + 1;
		end
		else begin
			low_len <= 0;
		end
	end

	a_ack_pulse: assert property (@(posedge CLK) disable iff (!RST_N) ack |=> !ack)
		else $error("ack high for more than one cycle");

	a_ack_busy: assert property (@(posedge CLK) disable iff (!RST_N)
		ack |-> $past(busy, 1) && $past(busy, 2))
		else $error("ack without two busy cycles before it");

	a_ovf_short: assert property (@(posedge CLK) disable iff (!RST_N)
		!wdtovf_n |-> low_len < WDTOVF_CYCLES)
		else $error("wdtovf_n low too long");

	a_ovf_width: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(wdtovf_n) |-> low_len == WDTOVF_CYCLES)
		else $error("wdtovf_n low pulse has the wrong width");

	a_no_joint: assert property (@(posedge CLK) disable iff (!RST_N)
		!($rose(iti_irq) && $fell(wdtovf_n)))
		else $error("iti_irq and wdtovf_n started in the same cycle");

endmodule

bind wdt_top wdt_properties u_props (
	.CLK      (CLK),
	.RST_N    (RST_N),
	.busy     (busy),
	.ack      (ack),
	.iti_irq  (iti_irq),
	.wdtovf_n (wdtovf_n)
);

//--- tb_wdt.sv
`timescale 1ns/1ps

module tb_wdt
	import wdt_pkg::*;
();

	localparam int     ACK_LIMIT = 16;
	localparam int     RATE_RUNS = 4;
	localparam int     MAX_TICKS = 36;
	localparam int     OVF_WAIT  = 256 * 2 * 2 + 64;
	// Slowest overflow, the rate runs at the slowest tap, and margin
	localparam longint RUN_LIMIT = 256 * 8192 + RATE_RUNS * (MAX_TICKS + 2) * 8192 + 20000;

	logic   CLK = 1'b0;
	logic   RST_N;
	logic   req;
	logic   we;
	addr_t  addr;
	word_t  wdata;
	logic   busy;
	logic   ack;
	word_t  rdata;
	logic   iti_irq;
	logic   wdtovf_n;

	int     errors = 0;
	int     checks = 0;
	longint cyc = 0;

	// Shadow registers
	byte_t  sh_tcsr = '0;
	byte_t  sh_tcnt = '0;
	byte_t  sh_rstcsr = '0;

	word_t  cmp_got;
	word_t  cmp_exp;
	string  cmp_what;
	event   rd_done;

	wdt_top u_dut (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.req      (req),
		.we       (we),
		.addr     (addr),
		.wdata    (wdata),
		.busy     (busy),
		.ack      (ack),
		.rdata    (rdata),
		.iti_irq  (iti_irq),
		.wdtovf_n (wdtovf_n)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) cyc <= cyc + 1;

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0d ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0d ns: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	function automatic void model_write(input addr_t a, input word_t d);
		if (a == ADDR_TCSR_TCNT_W && d[DATA_W-1:8] == KEY_TCSR) begin
			// Stopping the timer clears TCNT
			if (sh_tcsr[TCSR_TME_BIT] && !d[TCSR_TME_BIT])
				sh_tcnt = '0;
			sh_tcsr = {sh_tcsr[TCSR_OVF_BIT] & d[TCSR_OVF_BIT], d[TCSR_WT_BIT],
				d[TCSR_TME_BIT], 2'b00, d[CKS_W-1:0]};
		end
		else if (a == ADDR_TCSR_TCNT_W && d[DATA_W-1:8] == KEY_TCNT) begin
			sh_tcnt = d[7:0];
		end
		else if (a == ADDR_RSTCSR && d[DATA_W-1:8] == KEY_TCSR && d[7:0] == 8'h00) begin
			sh_rstcsr = '0;
		end
	endfunction

	function automatic word_t expect_read(input addr_t a);
		case (a)
			ADDR_TCSR_TCNT_W: return {8'h00, sh_tcsr};
			ADDR_TCNT_R:      return {8'h00, sh_tcnt};
			ADDR_RSTCSR:      return {8'h00, sh_rstcsr};
			default:          return '0;
		endcase
	endfunction

	function automatic int divisor(input logic [CKS_W-1:0] c);
		return 1 << PRESC_TAPS[c];
	endfunction

	task automatic bus_access(input logic wr, input addr_t a, input word_t d, output word_t rd);
		int lat;
		lat = 0;
		@(posedge CLK);
		req   <= 1'b1;
		we    <= wr;
		addr  <= a;
		wdata <= d;
		@(posedge CLK);
		req <= 1'b0;
		@(negedge CLK);
		check_bit(busy, 1'b1, "busy after request");
		while (!ack && lat < ACK_LIMIT) begin
			lat++;
			@(negedge CLK);
		end
		if (!ack) begin
			errors++;
			$display("Bus access to offset %0d got no ack", a);
		end
		check_word(word_t'(lat), word_t'(2), "ack latency");
		check_bit(busy, 1'b0, "busy during ack");
		rd = rdata;
	endtask

	task automatic write_reg(input addr_t a, input word_t d);
		word_t unused_rd;
		bus_access(1'b1, a, d, unused_rd);
		model_write(a, d);
	endtask

	task automatic read_reg(input addr_t a, input string what);
		word_t rd;
		bus_access(1'b0, a, '0, rd);
		cmp_got  = rd;
		cmp_exp  = expect_read(a);
		cmp_what = what;
		-> rd_done;
	endtask

	task automatic end_test(input string name, input int err_before);
		@(posedge CLK);
		$display("%s: %0d errors", name, errors - err_before);
	endtask

	always @(rd_done) check_word(cmp_got, cmp_exp, cmp_what);

	initial begin
		int unsigned      r;
		int               n;
		int               e0;
		int               low_len;
		int               ticks;
		int               got;
		longint           t0;
		word_t            rd;
		byte_t            key;
		logic [CKS_W-1:0] c;
		logic             seen;

		void'($urandom(32'he5c6));
		RST_N = 1'b0;
		req   = 1'b0;
		we    = 1'b0;
		addr  = '0;
		wdata = '0;
		repeat (8) @(posedge CLK);
		RST_N <= 1'b1;

		e0 = errors;
		for (int a = 0; a < 4; a++)
			read_reg(addr_t'(a), "read after reset");
		check_bit(iti_irq, 1'b0, "iti_irq after reset");
		check_bit(wdtovf_n, 1'b1, "wdtovf_n after reset");
		end_test("reset values", e0);

		e0 = errors;
		for (int i = 0; i < 24; i++) begin
			r = $urandom;
			key = (r[9:8] == 2'd0) ? KEY_TCSR : (r[9:8] == 2'd1) ? KEY_TCNT : r[23:16];
			// TME held low so TCNT stays put
			write_reg(r[11:10], {key, r[7:6], 1'b0, r[4:0]});
			for (int a = 0; a < 4; a++)
				read_reg(addr_t'(a), "read after keyed write");
		end
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCNT, r[31:24]});
		read_reg(ADDR_TCNT_R, "TCNT load with TME low");
		end_test("key protection", e0);

		e0 = errors;
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 8'h00});
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCNT, 8'hF0});
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 8'h20});
		n = 0;
		seen = 1'b0;
		while (!iti_irq && n < OVF_WAIT) begin
			@(negedge CLK);
			seen |= !wdtovf_n;
			n++;
		end
		if (!iti_irq) begin
			errors++;
			$display("Interval overflow did not raise iti_irq within %0d cycles", OVF_WAIT);
		end
		check_bit(seen, 1'b0, "wdtovf_n low in interval mode");
		sh_tcsr[TCSR_OVF_BIT] = 1'b1;
		read_reg(ADDR_TCSR_TCNT_W, "TCSR after interval overflow");
		read_reg(ADDR_RSTCSR, "RSTCSR after interval overflow");
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 8'h00});
		check_bit(iti_irq, 1'b0, "iti_irq after OVF clear");
		read_reg(ADDR_TCSR_TCNT_W, "TCSR after OVF clear");
		end_test("interval overflow", e0);

		e0 = errors;
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCNT, 8'hFC});
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 8'h60});
		n = 0;
		seen = 1'b0;
		while (wdtovf_n && n < OVF_WAIT) begin
			@(negedge CLK);
			seen |= iti_irq;
			n++;
		end
		low_len = 0;
		while (!wdtovf_n && low_len < OVF_WAIT) begin
			@(negedge CLK);
			low_len++;
		end
		check_word(word_t'(low_len), word_t'(WDTOVF_CYCLES), "wdtovf_n low width");
		check_bit(seen, 1'b0, "iti_irq in watchdog mode");
		sh_rstcsr[RSTCSR_WOVF_BIT] = 1'b1;
		write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 8'h00});
		read_reg(ADDR_RSTCSR, "WOVF after watchdog overflow");
		write_reg(ADDR_RSTCSR, {KEY_TCNT, 8'h00});
		read_reg(ADDR_RSTCSR, "WOVF after wrong key clear");
		write_reg(ADDR_RSTCSR, {KEY_TCSR, 8'h00});
		read_reg(ADDR_RSTCSR, "WOVF after clear");
		end_test("watchdog overflow", e0);

		e0 = errors;
		for (int i = 0; i < RATE_RUNS; i++) begin
			r = $urandom;
			c = r[CKS_W-1:0];
			ticks = 4 + int'(r[7:3]);
			write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 5'b00100, c});
			t0 = cyc;
			repeat (ticks * divisor(c)) @(posedge CLK);
			bus_access(1'b0, ADDR_TCNT_R, '0, rd);
			// Cycles from the start edge to the capture edge
			n = int'(cyc - t0) / divisor(c);
			got = int'(rd);
			check_bit(got >= n - 1 && got <= n + 1, 1'b1,
				$sformatf("TCNT rate for CKS %0d, read %0d near %0d", c, got, n));
			write_reg(ADDR_TCSR_TCNT_W, {KEY_TCSR, 8'h00});
		end
		read_reg(ADDR_TCNT_R, "TCNT after stop");
		read_reg(ADDR_TCNT_R, "TCNT after stop, second read");
		end_test("counting rate and stop", e0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(RUN_LIMIT * 4);
		$display("Run timed out after %0d clock cycles before the tests finished", RUN_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- project.f
wdt_pkg.sv
clk_prescaler.sv
wdt_bus_fsm.sv
wdt_regs.sv
wdt_counter.sv
wdt_top.sv
wdt_properties.sv
tb_wdt.sv

//--- Makefile
TOP := tb_wdt

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
